// File: hw/isaPkg.sv
// 16-bit ISA fields and opcodes; memory, branch, jump and halt encodings are left out on purpose
`default_nettype none
package isaPkg;
   localparam int dataWidth = 16;   // data word width fixed by the ISA
   localparam int regSelWidth = 3;  // eight architectural registers
   localparam int opWidth = 5;      // opcode in bits 15:11
   localparam int fnWidth = 2;      // R-type function in bits 1:0

   typedef struct packed {
      logic [opWidth-1:0] opcode;
      logic [regSelWidth-1:0] rs;   // bits 10:8
      logic [regSelWidth-1:0] rt;   // bits 7:5
      logic [regSelWidth-1:0] rd;   // bits 4:2
      logic [fnWidth-1:0] fn;
   } rFields;

   typedef struct packed {
      logic [opWidth-1:0] opcode;
      logic [regSelWidth-1:0] rs;
      logic [regSelWidth-1:0] rd;   // bits 7:5 here, not 4:2
      logic [4:0] imm5;
   } i1Fields;

   typedef struct packed {
      logic [opWidth-1:0] opcode;
      logic [regSelWidth-1:0] rs;   // also the destination for LBI and SLBI
      logic [7:0] imm8;
   } i2Fields;

   // one instruction word, three readings of it
   typedef union packed {
      rFields rFormat;
      i1Fields i1Format;
      i2Fields i2Format;
   } instrWord;

   localparam logic [opWidth-1:0] opAddi = 5'b01000;
   localparam logic [opWidth-1:0] opSubi = 5'b01001;  // imm - rs
   localparam logic [opWidth-1:0] opXori = 5'b01010;
   localparam logic [opWidth-1:0] opAndni = 5'b01011;
   localparam logic [opWidth-1:0] opSlbi = 5'b10010;
   localparam logic [opWidth-1:0] opRoli = 5'b10100;
   localparam logic [opWidth-1:0] opSlli = 5'b10101;
   localparam logic [opWidth-1:0] opRori = 5'b10110;
   localparam logic [opWidth-1:0] opSrli = 5'b10111;
   localparam logic [opWidth-1:0] opLbi = 5'b11000;
   localparam logic [opWidth-1:0] opBtr = 5'b11001;
   localparam logic [opWidth-1:0] opShift = 5'b11010;  // ROL SLL ROR SRL by fn
   localparam logic [opWidth-1:0] opArith = 5'b11011;  // ADD SUB XOR ANDN by fn
   localparam logic [opWidth-1:0] opSeq = 5'b11100;
   localparam logic [opWidth-1:0] opSlt = 5'b11101;
   localparam logic [opWidth-1:0] opSle = 5'b11110;
   localparam logic [opWidth-1:0] opSco = 5'b11111;

   localparam logic [fnWidth-1:0] fnFirst = 2'b00;
   localparam logic [fnWidth-1:0] fnSecond = 2'b01;
   localparam logic [fnWidth-1:0] fnThird = 2'b10;
   localparam logic [fnWidth-1:0] fnFourth = 2'b11;
endpackage
`default_nettype wire

// File: hw/aluPkg.sv
// execute-stage operation and set-compare codes; values match the reference decoder encoding
`default_nettype none
package aluPkg;
   localparam int aluOpWidth = 3;
   localparam int setWidth = 3;

   // shifts and rotates sit in the low half, adder and logic in the upper half
   localparam logic [aluOpWidth-1:0] opRol = 3'b000;
   localparam logic [aluOpWidth-1:0] opSll = 3'b001;
   localparam logic [aluOpWidth-1:0] opRor = 3'b010;
   localparam logic [aluOpWidth-1:0] opSrl = 3'b011;
   localparam logic [aluOpWidth-1:0] opAdd = 3'b100;  // also SUB with invA
   localparam logic [aluOpWidth-1:0] opAnd = 3'b101;  // ANDN with invB
   localparam logic [aluOpWidth-1:0] opOr = 3'b110;   // only SLBI
   localparam logic [aluOpWidth-1:0] opXor = 3'b111;

   // msb set means a compare result replaces the alu result
   localparam logic [setWidth-1:0] setNone = 3'b000;
   localparam logic [setWidth-1:0] setEq = 3'b100;
   localparam logic [setWidth-1:0] setLt = 3'b101;   // signed
   localparam logic [setWidth-1:0] setLe = 3'b110;   // signed
   localparam logic [setWidth-1:0] setCarry = 3'b111;
endpackage
`default_nettype wire

// File: hw/decode.sv
// decode stage, one instruction per cycle; unsupported opcodes leave exValid low and write nothing
`default_nettype none
module decode (
   input wire clk,
   input wire reset,
   input wire instrValid,                                 // one-cycle strobe
   input wire isaPkg::instrWord instr,
   input wire [isaPkg::dataWidth-1:0] rsData,             // async register file reads
   input wire [isaPkg::dataWidth-1:0] rtData,
   output logic [isaPkg::regSelWidth-1:0] rsSel,
   output logic [isaPkg::regSelWidth-1:0] rtSel,
   output logic exValid,
   output logic [aluPkg::aluOpWidth-1:0] exAluOp,
   output logic exInvA,
   output logic exInvB,
   output logic [aluPkg::setWidth-1:0] exSetCtrl,
   output logic exUseImm,
   output logic [isaPkg::dataWidth-1:0] exImm,
   output logic exLoadImm,
   output logic exShiftByte,
   output logic exBitReverse,
   output logic [isaPkg::regSelWidth-1:0] exRsSel,
   output logic [isaPkg::regSelWidth-1:0] exRtSel,
   output logic [isaPkg::dataWidth-1:0] exRsData,
   output logic [isaPkg::dataWidth-1:0] exRtData,
   output logic [isaPkg::regSelWidth-1:0] exDestReg
);
   logic [aluPkg::aluOpWidth-1:0] aluOp;
   logic [aluPkg::setWidth-1:0] setCtrl;
   logic invA, invB, useImm, zeroExt, useImm8;
   logic loadImm, shiftByte, bitReverse, supported;
   logic [isaPkg::regSelWidth-1:0] destReg;
   logic [isaPkg::dataWidth-1:0] imm5Ext, imm8Ext;

   assign rsSel = instr.rFormat.rs;  // bits 10:8 in every format
   assign rtSel = instr.rFormat.rt;  // bits 7:5, ignored by I-format ops

   always_comb begin
      aluOp = aluPkg::opRol;
      setCtrl = aluPkg::setNone;
      invA = 1'b0;
      invB = 1'b0;
      useImm = 1'b0;
      zeroExt = 1'b0;                 // sign extend unless told otherwise
      useImm8 = 1'b0;
      loadImm = 1'b0;
      shiftByte = 1'b0;
      bitReverse = 1'b0;
      supported = 1'b1;
      destReg = instr.rFormat.rd;     // R-type writes bits 4:2
      case (instr.rFormat.opcode)
         isaPkg::opAddi, isaPkg::opSubi, isaPkg::opXori, isaPkg::opAndni,
         isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli: begin
            destReg = instr.i1Format.rd;  // I-1 writes bits 7:5
            useImm = 1'b1;
            case (instr.rFormat.opcode)
               isaPkg::opAddi: aluOp = aluPkg::opAdd;
               isaPkg::opSubi: begin
                  aluOp = aluPkg::opAdd;
                  invA = 1'b1;                // imm - rs
               end
               isaPkg::opXori: begin
                  aluOp = aluPkg::opXor;
                  zeroExt = 1'b1;
               end
               isaPkg::opAndni: begin
                  aluOp = aluPkg::opAnd;
                  zeroExt = 1'b1;
                  invB = 1'b1;                // rs & ~imm
               end
               isaPkg::opRoli: aluOp = aluPkg::opRol;
               isaPkg::opSlli: aluOp = aluPkg::opSll;
               isaPkg::opRori: aluOp = aluPkg::opRor;
               default: aluOp = aluPkg::opSrl;  // SRLI
            endcase
         end
         isaPkg::opLbi: begin
            destReg = instr.i2Format.rs;
            useImm8 = 1'b1;
            loadImm = 1'b1;                   // sign-extended imm8 straight through
         end
         isaPkg::opSlbi: begin
            destReg = instr.i2Format.rs;
            useImm8 = 1'b1;
            zeroExt = 1'b1;
            useImm = 1'b1;
            shiftByte = 1'b1;                 // (rs << 8) | imm
            aluOp = aluPkg::opOr;
         end
         isaPkg::opBtr: bitReverse = 1'b1;
         isaPkg::opArith: begin
            case (instr.rFormat.fn)
               isaPkg::fnFirst: aluOp = aluPkg::opAdd;
               isaPkg::fnSecond: begin
                  aluOp = aluPkg::opAdd;
                  invA = 1'b1;                // rt - rs
               end
               isaPkg::fnThird: aluOp = aluPkg::opXor;
               isaPkg::fnFourth: begin
                  aluOp = aluPkg::opAnd;
                  invB = 1'b1;
               end
            endcase
         end
         isaPkg::opShift: begin
            case (instr.rFormat.fn)
               isaPkg::fnFirst: aluOp = aluPkg::opRol;
               isaPkg::fnSecond: aluOp = aluPkg::opSll;
               isaPkg::fnThird: aluOp = aluPkg::opRor;
               isaPkg::fnFourth: aluOp = aluPkg::opSrl;
            endcase
         end
         isaPkg::opSeq: setCtrl = aluPkg::setEq;
         isaPkg::opSlt: setCtrl = aluPkg::setLt;
         isaPkg::opSle: setCtrl = aluPkg::setLe;
         isaPkg::opSco: setCtrl = aluPkg::setCarry;
         default: supported = 1'b0;           // memory, branch, jump, halt, unknown
      endcase
   end

   assign imm5Ext = zeroExt ? {{(isaPkg::dataWidth-5){1'b0}}, instr.i1Format.imm5}
                            : {{(isaPkg::dataWidth-5){instr.i1Format.imm5[4]}}, instr.i1Format.imm5};
   assign imm8Ext = zeroExt ? {{(isaPkg::dataWidth-8){1'b0}}, instr.i2Format.imm8}
                            : {{(isaPkg::dataWidth-8){instr.i2Format.imm8[7]}}, instr.i2Format.imm8};

   always_ff @(posedge clk) begin
      if (reset) begin
         exValid <= 1'b0;
      end else begin
         exValid <= instrValid && supported;  // dropped ops never reach write back
      end
   end

   always_ff @(posedge clk) begin
      exAluOp <= aluOp;
      exInvA <= invA;
      exInvB <= invB;
      exSetCtrl <= setCtrl;
      exUseImm <= useImm;
      exImm <= useImm8 ? imm8Ext : imm5Ext;
      exLoadImm <= loadImm;
      exShiftByte <= shiftByte;
      exBitReverse <= bitReverse;
      exRsSel <= rsSel;                       // kept for forwarding compare
      exRtSel <= rtSel;
      exRsData <= rsData;                     // may be stale by one instruction
      exRtData <= rtData;
      exDestReg <= destReg;
   end
endmodule
`default_nettype wire

// File: hw/execute.sv
// combinational execute; forwards only from the retire register, older results come from the register file
`default_nettype none
module execute (
   input wire exValid,
   input wire [aluPkg::aluOpWidth-1:0] exAluOp,
   input wire exInvA,
   input wire exInvB,
   input wire [aluPkg::setWidth-1:0] exSetCtrl,
   input wire exUseImm,
   input wire [isaPkg::dataWidth-1:0] exImm,
   input wire exLoadImm,
   input wire exShiftByte,
   input wire exBitReverse,
   input wire [isaPkg::regSelWidth-1:0] exRsSel,
   input wire [isaPkg::regSelWidth-1:0] exRtSel,
   input wire [isaPkg::dataWidth-1:0] exRsData,
   input wire [isaPkg::dataWidth-1:0] exRtData,
   input wire [isaPkg::regSelWidth-1:0] exDestReg,
   input wire retireValid,
   input wire [isaPkg::regSelWidth-1:0] retireReg,
   input wire [isaPkg::dataWidth-1:0] retireData,
   output logic wbValid,
   output logic [isaPkg::regSelWidth-1:0] wbReg,
   output logic [isaPkg::dataWidth-1:0] wbData
);
   localparam int dw = isaPkg::dataWidth;

   logic [dw-1:0] rsVal, rtVal, opA, opB, sum, reversed, aluOut;
   logic [2*dw-1:0] rolWide, rorWide;
   logic [dw:0] carrySum;
   logic [3:0] amount;
   logic setBit;

   // previous instruction is still in flight to the register file
   assign rsVal = (retireValid && retireReg == exRsSel) ? retireData : exRsData;
   assign rtVal = (retireValid && retireReg == exRtSel) ? retireData : exRtData;

   assign opA = exInvA ? ~(exShiftByte ? {rsVal[7:0], 8'h00} : rsVal)
                       : (exShiftByte ? {rsVal[7:0], 8'h00} : rsVal);
   assign opB = exInvB ? ~(exUseImm ? exImm : rtVal) : (exUseImm ? exImm : rtVal);
   assign sum = opA + opB + {{(dw-1){1'b0}}, exInvA};  // ~a + b + 1 gives b - a

   assign amount = opB[3:0];               // shift counts use low four bits only
   assign rolWide = {opA, opA} << amount;
   assign rorWide = {opA, opA} >> amount;

   always_comb begin
      case (exAluOp)
         aluPkg::opRol: aluOut = rolWide[2*dw-1:dw];
         aluPkg::opSll: aluOut = opA << amount;
         aluPkg::opRor: aluOut = rorWide[dw-1:0];
         aluPkg::opSrl: aluOut = opA >> amount;
         aluPkg::opAdd: aluOut = sum;
         aluPkg::opAnd: aluOut = opA & opB;
         aluPkg::opOr: aluOut = opA | opB;
         default: aluOut = opA ^ opB;        // opXor
      endcase
   end

   always_comb begin
      for (int i = 0; i < dw; i++) begin
         reversed[i] = rsVal[dw-1-i];
      end
   end

   assign carrySum = {1'b0, rsVal} + {1'b0, rtVal};

   always_comb begin
      case (exSetCtrl)
         aluPkg::setEq: setBit = (rsVal == rtVal);
         aluPkg::setLt: setBit = ($signed(rsVal) < $signed(rtVal));
         aluPkg::setLe: setBit = ($signed(rsVal) <= $signed(rtVal));
         aluPkg::setCarry: setBit = carrySum[dw];   // unsigned carry out
         default: setBit = 1'b0;
      endcase
   end

   always_comb begin
      if (exLoadImm) begin
         wbData = exImm;                     // LBI
      end else if (exBitReverse) begin
         wbData = reversed;
      end else if (exSetCtrl != aluPkg::setNone) begin
         wbData = {{(dw-1){1'b0}}, setBit};
      end else begin
         wbData = aluOut;
      end
   end

   assign wbValid = exValid;
   assign wbReg = exDestReg;
endmodule
`default_nettype wire

// File: hw/result.sv
// register file and retire register; reads are asynchronous, a write shows up only after the clock edge
`default_nettype none
module result (
   input wire clk,
   input wire reset,
   input wire wbValid,
   input wire [isaPkg::regSelWidth-1:0] wbReg,
   input wire [isaPkg::dataWidth-1:0] wbData,
   input wire [isaPkg::regSelWidth-1:0] rsSel,
   input wire [isaPkg::regSelWidth-1:0] rtSel,
   output logic [isaPkg::dataWidth-1:0] rsData,
   output logic [isaPkg::dataWidth-1:0] rtData,
   output logic retireValid,
   output logic [isaPkg::regSelWidth-1:0] retireReg,
   output logic [isaPkg::dataWidth-1:0] retireData
);
   localparam int numRegs = 1 << isaPkg::regSelWidth;

   logic [isaPkg::dataWidth-1:0] regs [numRegs];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;                   // all registers start at zero
         end
         retireValid <= 1'b0;
      end else begin
         retireValid <= wbValid;             // one-cycle pulse per instruction
         if (wbValid) begin
            regs[wbReg] <= wbData;
         end
      end
   end

   // retire port doubles as the forwarding source for execute
   always_ff @(posedge clk) begin
      if (wbValid) begin
         retireReg <= wbReg;
         retireData <= wbData;
      end
   end

   assign rsData = regs[rsSel];
   assign rtData = regs[rtSel];
endmodule
`default_nettype wire

// File: hw/integerCore.sv
// integer core top; fixed two-edge latency, no stalls, no back-pressure on instrValid
`default_nettype none
module integerCore (
   input wire clk,
   input wire reset,
   input wire instrValid,
   input wire [isaPkg::dataWidth-1:0] instr,
   output logic retireValid,
   output logic [isaPkg::regSelWidth-1:0] retireReg,
   output logic [isaPkg::dataWidth-1:0] retireData
);
   logic [isaPkg::regSelWidth-1:0] rsSel, rtSel, exRsSel, exRtSel, exDestReg, wbReg;
   logic [isaPkg::dataWidth-1:0] rsData, rtData, exRsData, exRtData, exImm, wbData;
   logic [aluPkg::aluOpWidth-1:0] exAluOp;
   logic [aluPkg::setWidth-1:0] exSetCtrl;
   logic exValid, exInvA, exInvB, exUseImm, exLoadImm, exShiftByte, exBitReverse;
   logic wbValid;

   decode decode0 (
      .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
      .rsData(rsData), .rtData(rtData), .rsSel(rsSel), .rtSel(rtSel),
      .exValid(exValid), .exAluOp(exAluOp), .exInvA(exInvA), .exInvB(exInvB),
      .exSetCtrl(exSetCtrl), .exUseImm(exUseImm), .exImm(exImm), .exLoadImm(exLoadImm),
      .exShiftByte(exShiftByte), .exBitReverse(exBitReverse), .exRsSel(exRsSel),
      .exRtSel(exRtSel), .exRsData(exRsData), .exRtData(exRtData), .exDestReg(exDestReg)
   );

   execute execute0 (
      .exValid(exValid), .exAluOp(exAluOp), .exInvA(exInvA), .exInvB(exInvB),
      .exSetCtrl(exSetCtrl), .exUseImm(exUseImm), .exImm(exImm), .exLoadImm(exLoadImm),
      .exShiftByte(exShiftByte), .exBitReverse(exBitReverse), .exRsSel(exRsSel),
      .exRtSel(exRtSel), .exRsData(exRsData), .exRtData(exRtData), .exDestReg(exDestReg),
      .retireValid(retireValid), .retireReg(retireReg), .retireData(retireData),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
   );

   result result0 (
      .clk(clk), .reset(reset), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
      .rsSel(rsSel), .rtSel(rtSel), .rsData(rsData), .rtData(rtData),
      .retireValid(retireValid), .retireReg(retireReg), .retireData(retireData)
   );
endmodule
`default_nettype wire

// File: test/clockGen.sv
// free-running testbench clock, period fixed at 40 time units, starts low
`default_nettype none
module clockGen (
   output logic clk
);
   initial clk = 1'b0;
   always #20 clk = ~clk;   // half period
endmodule
`default_nettype wire

// File: test/integerCore_properties.sv
// port-level checks on integerCore, assumes the fixed two-edge latency and no stalls
`default_nettype none
module integerCore_properties (
   input wire clk,
   input wire reset,
   input wire instrValid,
   input wire [15:0] instr,
   input wire retireValid,
   input wire [2:0] retireReg,
   input wire [15:0] retireData
);
   logic known;
   assign known = (instr[15:11] inside {isaPkg::opAddi, isaPkg::opSubi, isaPkg::opXori,
      isaPkg::opAndni, isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli,
      isaPkg::opSlbi, isaPkg::opLbi, isaPkg::opBtr, isaPkg::opShift, isaPkg::opArith,
      isaPkg::opSeq, isaPkg::opSlt, isaPkg::opSle, isaPkg::opSco});

   quietInReset: assert property (@(posedge clk) reset |=> !retireValid)
      else $error("retire pulse while reset is held");
   fixedLatency: assert property (@(posedge clk) disable iff (reset)
      instrValid && known |-> ##2 retireValid) else $error("supported op did not retire");
   droppedSilent: assert property (@(posedge clk) disable iff (reset)
      instrValid && !known |-> ##2 !retireValid) else $error("dropped op retired");
   retireKnown: assert property (@(posedge clk) disable iff (reset)
      retireValid |-> !$isunknown({retireReg, retireData})) else $error("retire has X bits");
endmodule
`default_nettype wire

// File: test/integerCoreTb.sv
// directed tests against a reference model; inputs change and retires are checked on the falling edge
`default_nettype none
module integerCoreTb;
   localparam int cycleLimit = 2000;   // tests take about 300 cycles
   logic clk, reset, instrValid, retireValid;
   logic [15:0] instr, retireData;
   logic [2:0] retireReg;
   logic [15:0] refRegs [8];
   logic [2:0] expReg [$];
   logic [15:0] expData [$];
   logic [31:0] lcgState;
   int errors, checks, cycles;
   string testName;

   clockGen clockGen0 (.clk(clk));
   integerCore dut0 (.clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
      .retireValid(retireValid), .retireReg(retireReg), .retireData(retireData));
   bind integerCore integerCore_properties props0 (.*);

   function automatic logic [15:0] nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState[31:16];             // upper bits are the better ones
   endfunction

   function automatic logic [15:0] rotl(input logic [15:0] v, input int n);
      return (v << n) | (v >> (16 - n));
   endfunction

   function automatic logic [15:0] rInstr(input logic [4:0] op, input logic [2:0] rs,
         input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] fn);
      return {op, rs, rt, rd, fn};
   endfunction

   // reference model that applies one instruction to refRegs and queues the expected retire
   task automatic modelIssue(input logic [15:0] w);
      logic [15:0] a, b, s5, z5, s8, z8, r;
      logic [16:0] wide;
      logic [2:0] dest;
      logic ok;
      a = refRegs[w[10:8]];
      b = refRegs[w[7:5]];
      s5 = {{11{w[4]}}, w[4:0]};
      z5 = {11'd0, w[4:0]};
      s8 = {{8{w[7]}}, w[7:0]};
      z8 = {8'd0, w[7:0]};
      wide = {1'b0, a} + {1'b0, b};
      dest = w[4:2];
      ok = 1'b1;
      r = '0;
      case (w[15:11])
         isaPkg::opAddi: r = a + s5;
         isaPkg::opSubi: r = s5 - a;
         isaPkg::opXori: r = a ^ z5;
         isaPkg::opAndni: r = a & ~z5;
         isaPkg::opRoli: r = rotl(a, int'(w[3:0]));
         isaPkg::opSlli: r = a << w[3:0];
         isaPkg::opRori: r = rotl(a, (16 - int'(w[3:0])) % 16);
         isaPkg::opSrli: r = a >> w[3:0];
         isaPkg::opLbi: r = s8;
         isaPkg::opSlbi: r = (a << 8) | z8;
         isaPkg::opBtr: for (int i = 0; i < 16; i++) r[i] = a[15-i];
         isaPkg::opShift: case (w[1:0])
            2'd0: r = rotl(a, int'(b[3:0]));
            2'd1: r = a << b[3:0];
            2'd2: r = rotl(a, (16 - int'(b[3:0])) % 16);
            default: r = a >> b[3:0];
         endcase
         isaPkg::opArith: case (w[1:0])
            2'd0: r = a + b;
            2'd1: r = b - a;             // rt minus rs
            2'd2: r = a ^ b;
            default: r = a & ~b;
         endcase
         isaPkg::opSeq: r = {15'd0, a == b};
         isaPkg::opSlt: r = {15'd0, $signed(a) < $signed(b)};
         isaPkg::opSle: r = {15'd0, $signed(a) <= $signed(b)};
         isaPkg::opSco: r = {15'd0, wide[16]};
         default: ok = 1'b0;
      endcase
      if (w[15:11] inside {isaPkg::opAddi, isaPkg::opSubi, isaPkg::opXori, isaPkg::opAndni,
            isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli}) dest = w[7:5];
      if (w[15:11] inside {isaPkg::opLbi, isaPkg::opSlbi}) dest = w[10:8];
      if (ok) begin
         refRegs[dest] = r;
         expReg.push_back(dest);
         expData.push_back(r);
      end
   endtask

   task automatic issue(input logic [15:0] w);
      @(negedge clk);
      instrValid = 1'b1;
      instr = w;
      modelIssue(w);
   endtask

   // stop issuing, wait for the queue to empty, then report the test
   task automatic finishTest(input int errorsBefore);
      int waited;
      @(negedge clk);
      instrValid = 1'b0;
      waited = 0;
      while (expData.size() > 0 && waited < 8) begin
         @(negedge clk);
         waited++;
      end
      assert (expData.size() == 0) else begin
         errors++;
         $display("%s: %0d expected retires never arrived", testName, expData.size());
      end
      $display("%s done, %0d errors", testName, errors - errorsBefore);
   endtask

   always @(negedge clk) begin
      if (!reset && retireValid) begin
         checks++;
         assert (expData.size() > 0) else begin
            errors++;
            $display("%s: retire of r%0d with nothing outstanding", testName, retireReg);
         end
         if (expData.size() > 0) begin
            assert ({retireReg, retireData} == {expReg[0], expData[0]}) else begin
               errors++;
               $display("MISMATCH %s expected r%0d=%h actual r%0d=%h", testName,
                  expReg[0], expData[0], retireReg, retireData);
            end
            void'(expReg.pop_front());
            void'(expData.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycleLimit) begin
         $display("timeout after %0d cycles", cycles);
         $display("Test failed");
         $finish;
      end
   end

   task automatic loadImmTest();
      logic [15:0] v;
      int e;
      e = errors;
      testName = "loadImm";
      for (int r = 0; r < 8; r++) begin
         v = nextRandom();
         issue({isaPkg::opLbi, 3'(r), v[7:0]});
         v = nextRandom();
         issue({isaPkg::opSlbi, 3'(r), v[7:0]});   // forwards the LBI result
      end
      finishTest(e);
   endtask

   task automatic arithTest();
      logic [15:0] v;
      logic [2:0] prev;
      int e;
      e = errors;
      testName = "arith";
      prev = 3'd0;
      for (int i = 0; i < 24; i++) begin
         v = nextRandom();
         issue(rInstr(isaPkg::opArith, prev, v[2:0], v[5:3], 2'(i)));
         prev = v[5:3];                   // next rs depends on this result
      end
      finishTest(e);
   endtask

   task automatic immTest();
      logic [4:0] imms [4];
      logic [15:0] v;
      int e;
      e = errors;
      testName = "immArith";
      imms = '{5'h01, 5'h0f, 5'h10, 5'h1f};
      for (int op = 0; op < 4; op++) begin
         for (int k = 0; k < 4; k++) begin
            v = nextRandom();
            issue({isaPkg::opAddi + 5'(op), v[2:0], v[5:3], imms[k]});
         end
      end
      finishTest(e);
   endtask

   task automatic shiftTest();
      logic [15:0] v;
      int e;
      e = errors;
      testName = "shift";
      for (int amt = 0; amt < 16; amt++) begin
         issue({isaPkg::opLbi, 3'd7, 8'(amt)});   // r7 holds the shift count
         for (int k = 0; k < 4; k++) begin
            v = nextRandom();
            issue(rInstr(isaPkg::opShift, 3'(v[2:0] % 7), 3'd7, 3'(v[5:3] % 7), 2'(k)));
            issue({isaPkg::opRoli + 5'(k), 3'(v[8:6] % 7), 3'(v[11:9] % 7), 1'b0, 4'(amt)});
         end
      end
      for (int i = 0; i < 8; i++) begin
         v = nextRandom();
         issue(rInstr(isaPkg::opBtr, v[2:0], 3'd0, v[5:3], 2'd0));
      end
      finishTest(e);
   endtask

   task automatic compareTest();
      int pa [6];
      int pb [6];
      int e;
      e = errors;
      testName = "compare";
      pa = '{1, 3, 1, 3, 4, 4};
      pb = '{2, 1, 3, 4, 4, 3};
      issue({isaPkg::opLbi, 3'd1, 8'h05});
      issue({isaPkg::opLbi, 3'd2, 8'h05});
      issue({isaPkg::opLbi, 3'd3, 8'hfd});    // -3
      issue({isaPkg::opLbi, 3'd4, 8'h80});    // 0xff80 carries with r3
      for (int p = 0; p < 6; p++) begin
         for (int op = 0; op < 4; op++) begin
            issue(rInstr(isaPkg::opSeq + 5'(op), 3'(pa[p]), 3'(pb[p]), 3'd5 + 3'(op % 3), 2'd0));
         end
      end
      finishTest(e);
   endtask

   task automatic droppedTest();
      logic [4:0] dropped [6];
      logic [15:0] v;
      int e;
      e = errors;
      testName = "dropped";
      dropped = '{5'b10000, 5'b10001, 5'b10011, 5'b01100, 5'b00100, 5'b00000};
      for (int i = 0; i < 6; i++) begin
         v = nextRandom();
         issue({dropped[i], v[10:0]});
         issue({isaPkg::opXori, 3'd6, 3'd6, 5'(i)});
      end
      for (int r = 0; r < 8; r++) begin
         issue({isaPkg::opAddi, 3'(r), 3'(r), 5'd0});   // read back unchanged
      end
      finishTest(e);
   endtask

   initial begin
      reset = 1'b1;
      instrValid = 1'b0;
      instr = '0;
      lcgState = 32'h88fc_da3c;
      errors = 0;
      checks = 0;
      cycles = 0;
      testName = "reset";
      for (int r = 0; r < 8; r++) refRegs[r] = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      loadImmTest();
      arithTest();
      immTest();
      shiftTest();
      compareTest();
      droppedTest();
      $display("%0d retires checked, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end
endmodule
`default_nettype wire

// File: flist.f
hw/isaPkg.sv
hw/aluPkg.sv
hw/decode.sv
hw/execute.sv
hw/result.sv
hw/integerCore.sv
test/clockGen.sv
test/integerCore_properties.sv
test/integerCoreTb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module integerCoreTb -f flist.f -o simv \
   && { ./obj_dir/simv > sim.log 2>&1 || true; } \
   && cat sim.log \
   && ! grep -q "Test failed" sim.log \
   && grep -q "Test passed" sim.log \
   || { echo "simulation failed"; exit 1; }
